// File: filelist.f
+incdir+source
source/csum_pkg.sv
source/sync_fifo.sv
source/csum_wb_regs.sv
source/csum_engine.sv
source/csum_top.sv
verif/csum_checker.sv
verif/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then scan the log for the fail message
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f filelist.f --top-module tb_top -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    && ! grep -q "CHECKS FAILED" sim.log \
    && cat sim.log \
    && echo "Simulation passed" \
    || { cat sim.log 2>/dev/null; echo "Simulation failed"; exit 1; }

exit 0

// File: source/csum_defs.svh
`ifndef CSUM_DEFS_SVH
`define CSUM_DEFS_SVH

// FIFO depths, word FIFO kept off a power of two on purpose
`define CSUM_WORD_DEPTH 6
`define CSUM_RES_DEPTH 3

// Bus and datapath widths
`define CSUM_BUS_W 32
`define CSUM_ADR_W 2
`define CSUM_DATA_W 16
`define CSUM_CNT_W 8

// Register map, word addresses
`define CSUM_ADR_DATA 2'd0
`define CSUM_ADR_LAST 2'd1
`define CSUM_ADR_RESULT 2'd2
`define CSUM_ADR_STATUS 2'd3

// Status register bits
`define CSUM_ST_WORD_FULL 0
`define CSUM_ST_RES_EMPTY 1
`define CSUM_ST_OVERFLOW 2

`endif

// File: source/csum_engine.sv
`timescale 1ns/1ps
`include "csum_defs.svh"

module csum_engine (
    input  logic              clk,
    input  logic              reset,
    // Word FIFO read side
    input  logic              word_empty,
    input  csum_pkg::word_t   word_data,
    output logic              word_pop,
    // Result FIFO write side
    input  logic              res_full,
    output logic              res_push,
    output csum_pkg::result_t res_data
);

    // Running state for the open frame
    logic [`CSUM_DATA_W-1:0] sum;
    logic [`CSUM_CNT_W-1:0]  count;

    // State including the head word
    logic [`CSUM_DATA_W-1:0] sum_next;
    logic [`CSUM_CNT_W-1:0]  count_next;

    //////////////////////////////////////////////////////////////////////
    // Consume
    //////////////////////////////////////////////////////////////////////

    // One word per cycle and a full result FIFO stalls everything
    assign word_pop = ~word_empty & ~res_full;

    // Both wrap naturally
    assign sum_next   = sum + word_data.data;
    assign count_next = count + 1'b1;

    // Result goes out with the pop of the last word
    assign res_push       = word_pop & word_data.last;
    assign res_data.sum   = sum_next;
    assign res_data.count = count_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            sum   <= '0;
            count <= '0;
        end else if (word_pop) begin
            if (word_data.last) begin
                // Frame closed and state starts fresh
                sum   <= '0;
                count <= '0;
            end else begin
                sum   <= sum_next;
                count <= count_next;
            end
        end
    end

    // Head word waiting during a stall stays put until popped
    a_head_stable: assert property (@(posedge clk) disable iff (reset)
                                    (!word_empty && !word_pop) |=> $stable(word_data))
        else $error("csum_engine: head word changed while stalled");

endmodule

// File: source/csum_pkg.sv
`include "csum_defs.svh"

package csum_pkg;

    //////////////////////////////////////////////////////////////////////
    // Wishbone classic bus
    //////////////////////////////////////////////////////////////////////

    // Master to slave
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`CSUM_ADR_W-1:0] adr;
        logic [`CSUM_BUS_W-1:0] dat;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic                   ack;
        logic [`CSUM_BUS_W-1:0] dat;
    } wb_rsp_t;

    //////////////////////////////////////////////////////////////////////
    // FIFO payloads
    //////////////////////////////////////////////////////////////////////

    // One data word, last marks end of frame
    typedef struct packed {
        logic                    last;
        logic [`CSUM_DATA_W-1:0] data;
    } word_t;

    // Per-frame result, count lands in 23:16 and sum in 15:0 on readback
    typedef struct packed {
        logic [`CSUM_CNT_W-1:0]  count;
        logic [`CSUM_DATA_W-1:0] sum;
    } result_t;

endpackage

// File: source/csum_top.sv
`timescale 1ns/1ps
`include "csum_defs.svh"

module csum_top (
    input  logic              clk,
    input  logic              reset,
    input  csum_pkg::wb_req_t wb_req,
    output csum_pkg::wb_rsp_t wb_rsp
);

    // Word path
    logic              word_push;
    csum_pkg::word_t   word_in;
    logic              word_full;
    logic              word_pop;
    csum_pkg::word_t   word_out;
    logic              word_empty;

    // Result path
    logic              res_push;
    csum_pkg::result_t res_in;
    logic              res_full;
    logic              res_pop;
    csum_pkg::result_t res_out;
    logic              res_empty;

    //////////////////////////////////////////////////////////////////////
    // Bus side
    //////////////////////////////////////////////////////////////////////

    csum_wb_regs u_regs (
        .clk       (clk),
        .reset     (reset),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .word_push (word_push),
        .word_data (word_in),
        .word_full (word_full),
        .res_pop   (res_pop),
        .res_data  (res_out),
        .res_empty (res_empty)
    );

    //////////////////////////////////////////////////////////////////////
    // FIFOs and engine
    //////////////////////////////////////////////////////////////////////

    sync_fifo #(
        .DEPTH     (`CSUM_WORD_DEPTH),
        .payload_t (csum_pkg::word_t)
    ) u_word_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (word_push),
        .push_data (word_in),
        .full      (word_full),
        .pop       (word_pop),
        .pop_data  (word_out),
        .empty     (word_empty)
    );

    csum_engine u_engine (
        .clk        (clk),
        .reset      (reset),
        .word_empty (word_empty),
        .word_data  (word_out),
        .word_pop   (word_pop),
        .res_full   (res_full),
        .res_push   (res_push),
        .res_data   (res_in)
    );

    sync_fifo #(
        .DEPTH     (`CSUM_RES_DEPTH),
        .payload_t (csum_pkg::result_t)
    ) u_res_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (res_push),
        .push_data (res_in),
        .full      (res_full),
        .pop       (res_pop),
        .pop_data  (res_out),
        .empty     (res_empty)
    );

endmodule

// File: source/csum_wb_regs.sv
`timescale 1ns/1ps
`include "csum_defs.svh"

module csum_wb_regs (
    input  logic               clk,
    input  logic               reset,
    // Wishbone classic slave
    input  csum_pkg::wb_req_t  wb_req,
    output csum_pkg::wb_rsp_t  wb_rsp,
    // Word FIFO write side
    output logic               word_push,
    output csum_pkg::word_t    word_data,
    input  logic               word_full,
    // Result FIFO read side
    output logic               res_pop,
    input  csum_pkg::result_t  res_data,
    input  logic               res_empty
);

    // Width of zero fill above the result on readback
    localparam int RES_PAD = `CSUM_BUS_W - $bits(csum_pkg::result_t);

    logic                    ack;
    logic                    req_take;
    // Request captured when sampled and used in the ack cycle
    logic                    acc_we;
    logic [`CSUM_ADR_W-1:0]  acc_adr;
    logic [`CSUM_DATA_W-1:0] acc_dat;
    // Sticky overflow flag
    logic                    overflow;
    logic                    wr_word;
    logic                    wr_status;
    logic                    rd_result;
    logic [`CSUM_BUS_W-1:0]  rd_dat;

    //////////////////////////////////////////////////////////////////////
    // Handshake
    //////////////////////////////////////////////////////////////////////

    // A new request that is not the tail of one already acked
    assign req_take = wb_req.cyc & wb_req.stb & ~ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= req_take;
        end
    end

    always_ff @(posedge clk) begin
        if (req_take) begin
            acc_we  <= wb_req.we;
            acc_adr <= wb_req.adr;
            acc_dat <= wb_req.dat[`CSUM_DATA_W-1:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Decode in the ack cycle
    //////////////////////////////////////////////////////////////////////

    assign wr_word   = ack & acc_we &
                       ((acc_adr == `CSUM_ADR_DATA) | (acc_adr == `CSUM_ADR_LAST));
    assign wr_status = ack & acc_we & (acc_adr == `CSUM_ADR_STATUS);
    assign rd_result = ack & ~acc_we & (acc_adr == `CSUM_ADR_RESULT);

    // Word push is dropped when full
    assign word_push      = wr_word & ~word_full;
    assign word_data.last = (acc_adr == `CSUM_ADR_LAST);
    assign word_data.data = acc_dat;

    // Result pop only when something is there
    assign res_pop = rd_result & ~res_empty;

    // Overflow set by a lost write and cleared by a STATUS write
    always_ff @(posedge clk) begin
        if (reset) begin
            overflow <= 1'b0;
        end else if (wr_word && word_full) begin
            overflow <= 1'b1;
        end else if (wr_status) begin
            overflow <= 1'b0;
        end
    end

    // Read mux
    always_comb begin
        rd_dat = '0;
        if (ack && !acc_we) begin
            case (acc_adr)
                `CSUM_ADR_RESULT: begin
                    // Empty FIFO reads back zero
                    if (!res_empty) begin
                        rd_dat = {{RES_PAD{1'b0}}, res_data};
                    end
                end
                `CSUM_ADR_STATUS: begin
                    rd_dat[`CSUM_ST_WORD_FULL] = word_full;
                    rd_dat[`CSUM_ST_RES_EMPTY] = res_empty;
                    rd_dat[`CSUM_ST_OVERFLOW]  = overflow;
                end
                default: rd_dat = '0;
            endcase
        end
    end

    assign wb_rsp.ack = ack;
    assign wb_rsp.dat = rd_dat;

    // Master releases stb within the ack cycle so no second access starts
    a_stb_released: assert property (@(posedge clk) disable iff (reset) ack |-> !wb_req.stb)
        else $error("csum_wb_regs: stb still high at the end of the ack cycle");

endmodule

// File: source/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     reset,
    // Write side
    input  logic     push,
    input  payload_t push_data,
    output logic     full,
    // Read side
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty
);

    // Index width, at least one bit even for a single entry
    localparam int IW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // Entry storage
    payload_t mem [DEPTH];

    // Pointers, top bit is the phase
    logic [IW:0] wr_ptr;
    logic [IW:0] rd_ptr;

    logic do_push;
    logic do_pop;
    logic idx_equal;
    logic phase_diff;

    // Step a pointer, roll over at DEPTH and flip the phase
    function automatic logic [IW:0] ptr_next(input logic [IW:0] ptr);
        logic [IW:0] nxt;
        if (ptr[IW-1:0] == IW'(DEPTH - 1)) begin
            nxt = {~ptr[IW], {IW{1'b0}}};
        end else begin
            // No carry into phase, index stays below DEPTH-1 here
            nxt = {ptr[IW], ptr[IW-1:0] + 1'b1};
        end
        return nxt;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Status from registered pointers
    //////////////////////////////////////////////////////////////////////

    assign idx_equal  = (wr_ptr[IW-1:0] == rd_ptr[IW-1:0]);
    assign phase_diff = wr_ptr[IW] ^ rd_ptr[IW];
    assign full       = idx_equal & phase_diff;
    assign empty      = idx_equal & ~phase_diff;

    // Overrun and underrun requests are dropped
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    //////////////////////////////////////////////////////////////////////
    // Pointers and storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[IW-1:0]] <= push_data;
        end
    end

    // Head entry falls through
    assign pop_data = mem[rd_ptr[IW-1:0]];

    // Callers are expected to honour full and empty
    a_no_push_full: assert property (@(posedge clk) disable iff (reset) push |-> !full)
        else $error("sync_fifo: push while full");
    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
        else $error("sync_fifo: pop while empty");

endmodule

// File: verif/csum_checker.sv
`timescale 1ns/1ps
`include "csum_defs.svh"

module csum_checker (
    input  logic              clk,
    input  logic              reset,
    input  csum_pkg::wb_req_t wb_req,
    input  csum_pkg::wb_rsp_t wb_rsp,
    output int                error_count,
    output int                check_count
);

    // Model contents of both FIFOs
    csum_pkg::word_t   word_q[$];
    csum_pkg::result_t res_q[$];

    // Open frame of the model engine
    logic [`CSUM_DATA_W-1:0] run_sum;
    logic [`CSUM_CNT_W-1:0]  run_cnt;
    logic                    overflow_m;

    // Request sampled at the previous edge, ack due now
    logic              req_pending;
    csum_pkg::wb_req_t req_hold;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %s: got %08h expected %08h at %0t", name, got, exp, $time);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Access finishing in this cycle, seen against pre-edge state
    //////////////////////////////////////////////////////////////////////

    task automatic apply_access(input csum_pkg::wb_req_t req);
        csum_pkg::word_t   w;
        csum_pkg::result_t r;
        logic [31:0]       exp;
        exp = '0;
        if (req.we) begin
            if (req.adr == `CSUM_ADR_DATA || req.adr == `CSUM_ADR_LAST) begin
                // Room check on pending words only
                if (word_q.size() < `CSUM_WORD_DEPTH) begin
                    w.data = req.dat[`CSUM_DATA_W-1:0];
                    w.last = (req.adr == `CSUM_ADR_LAST);
                    word_q.push_back(w);
                end else begin
                    overflow_m = 1'b1;
                end
            end else if (req.adr == `CSUM_ADR_STATUS) begin
                overflow_m = 1'b0;
            end
        end else begin
            case (req.adr)
                `CSUM_ADR_RESULT: begin
                    // Oldest frame first, zero when none
                    if (res_q.size() > 0) begin
                        r   = res_q.pop_front();
                        exp = {8'h00, r.count, r.sum};
                    end
                    compare("wb_rsp.dat (RESULT)", wb_rsp.dat, exp);
                end
                `CSUM_ADR_STATUS: begin
                    exp[`CSUM_ST_WORD_FULL] = (word_q.size() == `CSUM_WORD_DEPTH);
                    exp[`CSUM_ST_RES_EMPTY] = (res_q.size() == 0);
                    exp[`CSUM_ST_OVERFLOW]  = overflow_m;
                    compare("wb_rsp.dat (STATUS)", wb_rsp.dat, exp);
                end
                default: compare("wb_rsp.dat (DATA/LAST)", wb_rsp.dat, exp);
            endcase
        end
    endtask

    // One word into the open frame, result out on the last one
    task automatic engine_step();
        csum_pkg::word_t   w;
        csum_pkg::result_t r;
        w       = word_q.pop_front();
        run_sum = run_sum + w.data;
        run_cnt = run_cnt + 8'd1;
        if (w.last) begin
            r.count = run_cnt;
            r.sum   = run_sum;
            res_q.push_back(r);
            run_sum = '0;
            run_cnt = '0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Per-cycle model
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin : model_step
        logic eng_go;
        if (reset) begin
            word_q.delete();
            res_q.delete();
            run_sum     = '0;
            run_cnt     = '0;
            overflow_m  = 1'b0;
            req_pending = 1'b0;
        end else begin
            // Engine moves with a word waiting and room for a result
            eng_go = (word_q.size() > 0) && (res_q.size() < `CSUM_RES_DEPTH);
            if (wb_rsp.ack && !req_pending) begin
                error_count++;
                $display("Ack seen with no request pending at %0t", $time);
            end else if (!wb_rsp.ack && req_pending) begin
                error_count++;
                $display("Request was not acknowledged in the next cycle at %0t", $time);
            end else if (wb_rsp.ack) begin
                apply_access(req_hold);
            end
            if (eng_go) begin
                engine_step();
            end
            req_pending = wb_req.cyc && wb_req.stb && !wb_rsp.ack;
            req_hold    = wb_req;
        end
    end

endmodule

// File: verif/tb_top.sv
`timescale 1ns/1ps
`include "csum_defs.svh"

module tb_top;

    localparam logic [31:0] SEED      = 32'h8428_3670;
    localparam int          ACK_LIMIT = 20;
    localparam int          POLL_LIMIT = 200;
    localparam int          RUN_LIMIT = 100000;

    logic              clk;
    logic              reset;
    csum_pkg::wb_req_t wb_req;
    csum_pkg::wb_rsp_t wb_rsp;
    int                error_count;
    int                check_count;
    int                timeout_count = 0;
    logic              run_done = 1'b0;
    // Frames sent and not yet read back
    int                outstanding;
    logic [31:0]       rdat;
    int                i;

    csum_top dut (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    csum_checker u_checker (
        .clk         (clk),
        .reset       (reset),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .error_count (error_count),
        .check_count (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Bus master
    //////////////////////////////////////////////////////////////////////

    // Classic cycle held until ack and dropped on the falling edge after it
    task automatic bus_access(input logic we, input logic [1:0] adr,
                              input logic [31:0] dat, output logic [31:0] rd);
        int waited;
        waited = 0;
        rd     = '0;
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        @(negedge clk);
        while (!wb_rsp.ack && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (wb_rsp.ack) begin
            rd = wb_rsp.dat;
        end else begin
            timeout_count++;
            $display("Timeout waiting for ack on address %0d", adr);
        end
        wb_req = '0;
    endtask

    task automatic write_reg(input logic [1:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        bus_access(1'b1, adr, dat, unused);
    endtask

    task automatic read_reg(input logic [1:0] adr, output logic [31:0] rd);
        bus_access(1'b0, adr, '0, rd);
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Poll until result-empty drops and then read one result
    task automatic fetch_result();
        logic [31:0] st;
        logic [31:0] res;
        int          polls;
        polls = 0;
        read_reg(`CSUM_ADR_STATUS, st);
        while (st[`CSUM_ST_RES_EMPTY] && polls < POLL_LIMIT) begin
            read_reg(`CSUM_ADR_STATUS, st);
            polls++;
        end
        if (st[`CSUM_ST_RES_EMPTY]) begin
            timeout_count++;
            $display("Timeout waiting for a result to appear");
        end
        read_reg(`CSUM_ADR_RESULT, res);
        outstanding--;
    endtask

    // Random words with LAST on the final one plus random polls and gaps
    task automatic send_frame(input int len);
        logic [31:0] poll;
        int          k;
        for (k = 0; k < len; k++) begin
            if (k == len - 1) begin
                write_reg(`CSUM_ADR_LAST, $urandom);
            end else begin
                write_reg(`CSUM_ADR_DATA, $urandom);
            end
            if ($urandom_range(0, 3) == 0) begin
                read_reg(`CSUM_ADR_STATUS, poll);
            end
            idle($urandom_range(0, 2));
        end
        outstanding++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        wb_req      = '0;
        reset       = 1'b1;
        outstanding = 0;
        void'($urandom(SEED));
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Idle state after reset
        read_reg(`CSUM_ADR_STATUS, rdat);
        read_reg(`CSUM_ADR_RESULT, rdat);
        // Write-only ports read as zero
        read_reg(`CSUM_ADR_DATA, rdat);
        read_reg(`CSUM_ADR_LAST, rdat);

        // Random frames with never more outstanding than the result FIFO holds
        for (i = 0; i < 24; i++) begin
            if (outstanding == `CSUM_RES_DEPTH) begin
                fetch_result();
            end
            send_frame($urandom_range(1, 8));
            if ($urandom_range(0, 1) == 1) begin
                fetch_result();
            end
            idle($urandom_range(0, 4));
        end
        while (outstanding > 0) begin
            fetch_result();
        end

        // Queue a full result FIFO and read it back in order
        for (i = 0; i < `CSUM_RES_DEPTH; i++) begin
            send_frame($urandom_range(1, 4));
        end
        for (i = 0; i < `CSUM_RES_DEPTH; i++) begin
            fetch_result();
        end

        // Stall the engine and fill the word FIFO so one write is lost
        for (i = 0; i < `CSUM_RES_DEPTH; i++) begin
            send_frame(1);
        end
        for (i = 0; i < `CSUM_WORD_DEPTH; i++) begin
            write_reg(`CSUM_ADR_DATA, $urandom);
        end
        read_reg(`CSUM_ADR_STATUS, rdat);
        write_reg(`CSUM_ADR_DATA, $urandom);
        read_reg(`CSUM_ADR_STATUS, rdat);
        for (i = 0; i < `CSUM_RES_DEPTH; i++) begin
            fetch_result();
        end
        // Close the stalled frame
        write_reg(`CSUM_ADR_LAST, $urandom);
        outstanding++;
        fetch_result();

        // Overflow clear
        write_reg(`CSUM_ADR_STATUS, '0);
        read_reg(`CSUM_ADR_STATUS, rdat);
        read_reg(`CSUM_ADR_STATUS, rdat);
        run_done = 1'b1;
    end

    // Run limit and closing report
    initial begin : report
        int cycles;
        cycles = 0;
        while (!run_done && timeout_count == 0 && cycles < RUN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= RUN_LIMIT) begin
            timeout_count++;
            $display("Timeout: run did not finish within %0d cycles", RUN_LIMIT);
        end
        // Last ack still to be checked
        repeat (2) @(posedge clk);
        $display("Summary: %0d checks, %0d errors, %0d timeouts",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
